// ==== Makefile ====
# Verilator build and run of the board I/O testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := board_io_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/board_io_pkg.sv ====
// Package with the GPIO button and switch struct type

`default_nettype none

package board_io_pkg;

    // Raw and debounced board GPIO share one layout
    typedef struct packed {
        logic [1:0] button;
        logic [1:0] sw;
    } gpio_t;

endpackage

`default_nettype wire

// ==== hdl/board_io_top.sv ====
// Top level with reset synchronizer, GPIO debouncer and two QSFP-DD cage conditioners

`timescale 1ns/100ps
`default_nettype none

`include "board_io_defines.svh"

module board_io_top #(
    parameter int DEBOUNCE_RATE = `DEBOUNCE_RATE_DEFAULT
) (
    input  logic                 pcie_clk,
    input  logic                 arst_n_i,

    // Buttons and switches
    input  board_io_pkg::gpio_t  gpio_i,
    output board_io_pkg::gpio_t  gpio_o,

    // Cage sideband inputs
    input  qsfp_pkg::sideband_t  qsfpdda_pins_i,
    input  qsfp_pkg::sideband_t  qsfpddb_pins_i,
    output qsfp_pkg::sideband_t  qsfpdda_sync_o,
    output qsfp_pkg::sideband_t  qsfpddb_sync_o,

    // I2C drive from the core towards the pins
    input  qsfp_pkg::i2c_drive_t qsfpdda_drive_i,
    input  qsfp_pkg::i2c_drive_t qsfpddb_drive_i,
    output qsfp_pkg::i2c_drive_t qsfpdda_drive_o,
    output qsfp_pkg::i2c_drive_t qsfpddb_drive_o,

    output logic                 ctrl_rst_o
);

    logic ctrl_rst;

    reset_sync reset_sync_inst (
        .pcie_clk (pcie_clk),
        .arst_n_i (arst_n_i),
        .rst_o    (ctrl_rst)
    );

    assign ctrl_rst_o = ctrl_rst;

    // Debouncer runs from the delayed control reset
    gpio_debounce #(
        .RATE (DEBOUNCE_RATE)
    ) gpio_debounce_inst (
        .pcie_clk (pcie_clk),
        .rst_i    (ctrl_rst),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o)
    );

    // Cage A
    qsfp_sideband qsfpdda_sideband (
        .pcie_clk (pcie_clk),
        .arst_n_i (arst_n_i),
        .pins_i   (qsfpdda_pins_i),
        .sync_o   (qsfpdda_sync_o),
        .drive_i  (qsfpdda_drive_i),
        .drive_o  (qsfpdda_drive_o)
    );

    // Cage B
    qsfp_sideband qsfpddb_sideband (
        .pcie_clk (pcie_clk),
        .arst_n_i (arst_n_i),
        .pins_i   (qsfpddb_pins_i),
        .sync_o   (qsfpddb_sync_o),
        .drive_i  (qsfpddb_drive_i),
        .drive_o  (qsfpddb_drive_o)
    );

endmodule

`default_nettype wire

// ==== hdl/gpio_debounce.sv ====
// Rate-ticked sampler and per-bit debounce of buttons and switches

`timescale 1ns/100ps
`default_nettype none

`include "board_io_defines.svh"

module gpio_debounce #(
    parameter int RATE = `DEBOUNCE_RATE_DEFAULT
) (
    input  logic                pcie_clk,
    input  logic                rst_i,
    input  board_io_pkg::gpio_t gpio_i,
    output board_io_pkg::gpio_t gpio_o
);

    localparam int W     = $bits(board_io_pkg::gpio_t);
    localparam int N     = `DEBOUNCE_SAMPLES;
    localparam int CNT_W = $clog2(RATE);

    logic [CNT_W-1:0]    rate_cnt_q;
    logic                sample_tick;
    logic [W-1:0]        in_bits;
    logic [W-1:0][N-1:0] hist_q;
    logic [W-1:0]        out_q;

    assign in_bits = gpio_i;

    // Free-running sample tick, one pulse every RATE cycles
    assign sample_tick = (rate_cnt_q == CNT_W'(RATE - 1));

    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            rate_cnt_q <= '0;
        end else if (sample_tick) begin
            rate_cnt_q <= '0;
        end else begin
            rate_cnt_q <= rate_cnt_q + 1'b1;
        end
    end

    // Sample history, newest entry in bit 0
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            hist_q <= '0;
        end else if (sample_tick) begin
            for (int i = 0; i < W; i++) begin
                hist_q[i] <= {hist_q[i][N-2:0], in_bits[i]};
            end
        end
    end

    // Flip only on a full run of equal samples, otherwise hold
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            out_q <= '0;
        end else begin
            for (int i = 0; i < W; i++) begin
                if (&hist_q[i]) begin
                    out_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    out_q[i] <= 1'b0;
                end
            end
        end
    end

    assign gpio_o = out_q;

endmodule

`default_nettype wire

// ==== hdl/qsfp_pkg.sv ====
// Package with QSFP-DD sideband and I2C open-drain drive types

`default_nettype none

package qsfp_pkg;

    // Cage inputs, all idle high
    typedef struct packed {
        logic interrupt_n;
        logic mod_prs_n;
        logic scl;
        logic sda;
    } sideband_t;

    // Open-drain drive, t set means the line is released
    typedef struct packed {
        logic scl_o;
        logic scl_t;
        logic sda_o;
        logic sda_t;
    } i2c_drive_t;

    // Both lines released
    localparam i2c_drive_t I2C_DRIVE_IDLE = '{
        scl_o: 1'b0,
        scl_t: 1'b1,
        sda_o: 1'b0,
        sda_t: 1'b1
    };

endpackage

`default_nettype wire

// ==== hdl/qsfp_sideband.sv ====
// Two-flop synchronizer for one cage's inputs and register for its I2C drive

`timescale 1ns/100ps
`default_nettype none

`include "board_io_defines.svh"

module qsfp_sideband (
    input  logic                 pcie_clk,
    input  logic                 arst_n_i,
    input  qsfp_pkg::sideband_t  pins_i,
    output qsfp_pkg::sideband_t  sync_o,
    input  qsfp_pkg::i2c_drive_t drive_i,
    output qsfp_pkg::i2c_drive_t drive_o
);

    qsfp_pkg::sideband_t  sync_q [`SYNC_STAGES];
    qsfp_pkg::i2c_drive_t drive_q;

    // Idle level of the active-low inputs is high
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < `SYNC_STAGES; s++) begin
                sync_q[s] <= '1;
            end
        end else begin
            sync_q[0] <= pins_i;
            for (int s = 1; s < `SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    assign sync_o = sync_q[`SYNC_STAGES-1];

    // Tristate control leaves the FPGA from a flop
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            drive_q <= qsfp_pkg::I2C_DRIVE_IDLE;
        end else begin
            drive_q <= drive_i;
        end
    end

    assign drive_o = drive_q;

endmodule

`default_nettype wire

// ==== hdl/reset_sync.sv ====
// Reset synchronizer with asynchronous assert and delayed synchronous release

`timescale 1ns/100ps
`default_nettype none

`include "board_io_defines.svh"

module reset_sync (
    input  logic pcie_clk,
    input  logic arst_n_i,
    output logic rst_o
);

    logic [`RST_SYNC_STAGES-1:0] chain_q;

    // All stages set at once, zeros walk through after release
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            chain_q <= '1;
        end else begin
            chain_q <= {chain_q[`RST_SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign rst_o = chain_q[`RST_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== include/board_io_defines.svh ====
// Stage counts and debounce rate defaults for board I/O conditioning

`ifndef BOARD_IO_DEFINES_SVH
`define BOARD_IO_DEFINES_SVH

// Reset release chain length in pcie_clk cycles
`define RST_SYNC_STAGES 20

// Synchronizer depth for asynchronous cage inputs
`define SYNC_STAGES 2

// Equal consecutive samples needed to flip a debounced bit
`define DEBOUNCE_SAMPLES 4

// Clock cycles between debounce samples, about 1 ms at 250 MHz
`define DEBOUNCE_RATE_DEFAULT 250000

`endif

// ==== tb.f ====
+incdir+include
hdl/board_io_pkg.sv
hdl/qsfp_pkg.sv
hdl/reset_sync.sv
hdl/gpio_debounce.sv
hdl/qsfp_sideband.sv
hdl/board_io_top.sv
tb/board_io_props.sv
tb/board_io_tb.sv

// ==== tb/board_io_props.sv ====
// Bound assertions on control reset and cage sideband register latencies

`timescale 1ns/100ps
`default_nettype none

module board_io_props (
    input logic                 pcie_clk,
    input logic                 arst_n_i,
    input logic                 ctrl_rst_i,
    input qsfp_pkg::sideband_t  qsfpdda_pins_i,
    input qsfp_pkg::sideband_t  qsfpdda_sync_i,
    input qsfp_pkg::i2c_drive_t qsfpdda_core_drive_i,
    input qsfp_pkg::i2c_drive_t qsfpdda_pin_drive_i,
    input qsfp_pkg::sideband_t  qsfpddb_pins_i,
    input qsfp_pkg::sideband_t  qsfpddb_sync_i,
    input qsfp_pkg::i2c_drive_t qsfpddb_core_drive_i,
    input qsfp_pkg::i2c_drive_t qsfpddb_pin_drive_i
);

    // Control reset follows the asynchronous reset at once
    rst_held: assert property (@(posedge pcie_clk) !arst_n_i |-> ctrl_rst_i)
        else $error("control reset low while arst_n_i is asserted");

    // Drive register is one cycle deep
    drive_a_latency: assert property (@(posedge pcie_clk)
        arst_n_i && $past(arst_n_i) |-> qsfpdda_pin_drive_i == $past(qsfpdda_core_drive_i))
        else $error("cage a drive is not the previous cycle's drive");

    drive_b_latency: assert property (@(posedge pcie_clk)
        arst_n_i && $past(arst_n_i) |-> qsfpddb_pin_drive_i == $past(qsfpddb_core_drive_i))
        else $error("cage b drive is not the previous cycle's drive");

    // Two flops per input, checked once both have left reset
    sync_a_latency: assert property (@(posedge pcie_clk)
        arst_n_i && $past(arst_n_i) && $past(arst_n_i, 2)
        |-> qsfpdda_sync_i == $past(qsfpdda_pins_i, 2))
        else $error("cage a sync output is not the pins from two cycles earlier");

    sync_b_latency: assert property (@(posedge pcie_clk)
        arst_n_i && $past(arst_n_i) && $past(arst_n_i, 2)
        |-> qsfpddb_sync_i == $past(qsfpddb_pins_i, 2))
        else $error("cage b sync output is not the pins from two cycles earlier");

endmodule

bind board_io_top board_io_props board_io_props_inst (
    .pcie_clk             (pcie_clk),
    .arst_n_i             (arst_n_i),
    .ctrl_rst_i           (ctrl_rst_o),
    .qsfpdda_pins_i       (qsfpdda_pins_i),
    .qsfpdda_sync_i       (qsfpdda_sync_o),
    .qsfpdda_core_drive_i (qsfpdda_drive_i),
    .qsfpdda_pin_drive_i  (qsfpdda_drive_o),
    .qsfpddb_pins_i       (qsfpddb_pins_i),
    .qsfpddb_sync_i       (qsfpddb_sync_o),
    .qsfpddb_core_drive_i (qsfpddb_drive_i),
    .qsfpddb_pin_drive_i  (qsfpddb_drive_o)
);

`default_nettype wire

// ==== tb/board_io_tb.sv ====
// Testbench for board_io_top with xorshift stimulus, reference model and compare tasks

`timescale 1ns/100ps
`default_nettype none

`include "board_io_defines.svh"

module board_io_tb;

    localparam int DEB_RATE      = 4;
    localparam int GPIO_W        = $bits(board_io_pkg::gpio_t);
    localparam int SETTLE_CYCLES = (`DEBOUNCE_SAMPLES + 1) * DEB_RATE;
    localparam int HOLD_CYCLES   = 30;

    localparam qsfp_pkg::sideband_t  SIDE_IDLE = '1;
    localparam qsfp_pkg::i2c_drive_t DRIVE_RELEASED = '{
        scl_o: 1'b0,
        scl_t: 1'b1,
        sda_o: 1'b0,
        sda_t: 1'b1
    };

    logic                 pcie_clk;
    logic                 arst_n_i;
    board_io_pkg::gpio_t  gpio_i;
    board_io_pkg::gpio_t  gpio_o;
    qsfp_pkg::sideband_t  qsfpdda_pins_i;
    qsfp_pkg::sideband_t  qsfpddb_pins_i;
    qsfp_pkg::sideband_t  qsfpdda_sync_o;
    qsfp_pkg::sideband_t  qsfpddb_sync_o;
    qsfp_pkg::i2c_drive_t qsfpdda_drive_i;
    qsfp_pkg::i2c_drive_t qsfpddb_drive_i;
    qsfp_pkg::i2c_drive_t qsfpdda_drive_o;
    qsfp_pkg::i2c_drive_t qsfpddb_drive_o;
    logic                 ctrl_rst_o;

    // Reference model state
    logic [31:0]          rng_state;
    qsfp_pkg::sideband_t  sync_exp_a [$];
    qsfp_pkg::sideband_t  sync_exp_b [$];
    qsfp_pkg::i2c_drive_t drive_exp_a [$];
    qsfp_pkg::i2c_drive_t drive_exp_b [$];
    board_io_pkg::gpio_t  applied_gpio;
    board_io_pkg::gpio_t  model_gpio;
    int                   stable_cnt [GPIO_W];

    board_io_top #(
        .DEBOUNCE_RATE (DEB_RATE)
    ) DUT (
        .pcie_clk        (pcie_clk),
        .arst_n_i        (arst_n_i),
        .gpio_i          (gpio_i),
        .gpio_o          (gpio_o),
        .qsfpdda_pins_i  (qsfpdda_pins_i),
        .qsfpddb_pins_i  (qsfpddb_pins_i),
        .qsfpdda_sync_o  (qsfpdda_sync_o),
        .qsfpddb_sync_o  (qsfpddb_sync_o),
        .qsfpdda_drive_i (qsfpdda_drive_i),
        .qsfpddb_drive_i (qsfpddb_drive_i),
        .qsfpdda_drive_o (qsfpdda_drive_o),
        .qsfpddb_drive_o (qsfpddb_drive_o),
        .ctrl_rst_o      (ctrl_rst_o)
    );

    initial begin
        pcie_clk = 1'b0;
        forever #10 pcie_clk = ~pcie_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic abort_sim();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_gpio(input board_io_pkg::gpio_t actual,
                              input board_io_pkg::gpio_t expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, expected %b got %b", $time, what, expected, actual);
            abort_sim();
        end
    endtask

    task automatic check_sideband(input qsfp_pkg::sideband_t actual,
                                  input qsfp_pkg::sideband_t expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, expected %b got %b", $time, what, expected, actual);
            abort_sim();
        end
    endtask

    task automatic check_drive(input qsfp_pkg::i2c_drive_t actual,
                               input qsfp_pkg::i2c_drive_t expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, expected %b got %b", $time, what, expected, actual);
            abort_sim();
        end
    endtask

    task automatic check_rst(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, expected %b got %b", $time, what, expected, actual);
            abort_sim();
        end
    endtask

    // One clock: drive on the rising edge, check the cages on the falling edge
    task automatic step(input board_io_pkg::gpio_t g, input logic rst_n, input logic random_side);
        qsfp_pkg::sideband_t  pa;
        qsfp_pkg::sideband_t  pb;
        qsfp_pkg::i2c_drive_t da;
        qsfp_pkg::i2c_drive_t db;
        logic [31:0]          r;
        logic [GPIO_W-1:0]    g_bits;
        logic [GPIO_W-1:0]    prev_bits;
        logic [GPIO_W-1:0]    model_bits;
        pa = SIDE_IDLE;
        pb = SIDE_IDLE;
        da = DRIVE_RELEASED;
        db = DRIVE_RELEASED;
        if (random_side) begin
            r  = next_rand();
            pa = qsfp_pkg::sideband_t'(r[3:0]);
            pb = qsfp_pkg::sideband_t'(r[7:4]);
            da = qsfp_pkg::i2c_drive_t'(r[11:8]);
            db = qsfp_pkg::i2c_drive_t'(r[15:12]);
        end
        @(posedge pcie_clk);
        arst_n_i        <= rst_n;
        gpio_i          <= g;
        qsfpdda_pins_i  <= pa;
        qsfpddb_pins_i  <= pb;
        qsfpdda_drive_i <= da;
        qsfpddb_drive_i <= db;
        sync_exp_a.push_back(pa);
        sync_exp_b.push_back(pb);
        drive_exp_a.push_back(da);
        drive_exp_b.push_back(db);
        // A bit counts as settled once it stayed put past the debounce bound
        g_bits     = g;
        prev_bits  = applied_gpio;
        model_bits = model_gpio;
        for (int i = 0; i < GPIO_W; i++) begin
            if (g_bits[i] != prev_bits[i]) begin
                stable_cnt[i] = 0;
            end else if (stable_cnt[i] <= SETTLE_CYCLES) begin
                stable_cnt[i]++;
            end
            if (stable_cnt[i] > SETTLE_CYCLES) begin
                model_bits[i] = g_bits[i];
            end
        end
        applied_gpio = g;
        model_gpio   = model_bits;
        @(negedge pcie_clk);
        check_sideband(qsfpdda_sync_o, sync_exp_a.pop_front(), "cage a sync");
        check_sideband(qsfpddb_sync_o, sync_exp_b.pop_front(), "cage b sync");
        check_drive(qsfpdda_drive_o, drive_exp_a.pop_front(), "cage a drive");
        check_drive(qsfpddb_drive_o, drive_exp_b.pop_front(), "cage b drive");
    endtask

    initial begin
        logic [31:0]         r;
        logic [GPIO_W-1:0]   mask;
        board_io_pkg::gpio_t target;
        board_io_pkg::gpio_t settled;
        int                  waited;
        int                  glitch_len;
        int                  gap;
        arst_n_i        = 1'b1;
        gpio_i          = '0;
        qsfpdda_pins_i  = SIDE_IDLE;
        qsfpddb_pins_i  = SIDE_IDLE;
        qsfpdda_drive_i = DRIVE_RELEASED;
        qsfpddb_drive_i = DRIVE_RELEASED;
        rng_state       = 32'hca48;
        applied_gpio    = '0;
        model_gpio      = '0;
        for (int i = 0; i < GPIO_W; i++) begin
            stable_cnt[i] = 0;
        end
        sync_exp_a.push_back(SIDE_IDLE);
        sync_exp_a.push_back(SIDE_IDLE);
        sync_exp_b.push_back(SIDE_IDLE);
        sync_exp_b.push_back(SIDE_IDLE);
        drive_exp_a.push_back(DRIVE_RELEASED);
        drive_exp_b.push_back(DRIVE_RELEASED);

        // Reset values, then release after exactly RST_SYNC_STAGES edges
        for (int j = 0; j < 16; j++) begin
            step('0, 1'b0, 1'b0);
            check_rst(ctrl_rst_o, 1'b1, "ctrl_rst_o during reset");
            if (j > 0) begin
                check_gpio(gpio_o, '0, "gpio_o during reset");
            end
        end
        step('0, 1'b1, 1'b0);
        check_rst(ctrl_rst_o, 1'b1, "ctrl_rst_o at reset release");
        for (int j = 1; j <= `RST_SYNC_STAGES; j++) begin
            step('0, 1'b1, 1'b0);
            check_rst(ctrl_rst_o, j < `RST_SYNC_STAGES, "ctrl_rst_o release delay");
            check_gpio(gpio_o, '0, "gpio_o right after reset");
        end

        // Random cage inputs and I2C drive, checked inside each step
        for (int j = 0; j < 200; j++) begin
            step('0, 1'b1, 1'b1);
        end

        // Held GPIO values must reach the output within the debounce bound
        for (int v = 0; v < 12; v++) begin
            r      = next_rand();
            target = board_io_pkg::gpio_t'(r[3:0]);
            step(target, 1'b1, 1'b1);
            waited = 1;
            while (gpio_o !== target) begin
                if (waited >= SETTLE_CYCLES) begin
                    $display("timeout at %0d ns: gpio_o did not reach %b within %0d cycles",
                             $time, target, SETTLE_CYCLES);
                    abort_sim();
                end else begin
                    step(target, 1'b1, 1'b1);
                    waited++;
                end
            end
            while (waited < HOLD_CYCLES) begin
                step(target, 1'b1, 1'b1);
                waited++;
                check_gpio(gpio_o, target, "held gpio value");
            end
        end

        // Glitches shorter than one sample period stay invisible
        settled = model_gpio;
        for (int k = 0; k < 20; k++) begin
            r    = next_rand();
            mask = r[3:0];
            if (mask == '0) begin
                mask = 4'b0001;
            end
            glitch_len = 1 + int'(r[9:8]) % 3;
            gap        = 5 + int'(r[13:12]);
            for (int c = 0; c < glitch_len; c++) begin
                step(board_io_pkg::gpio_t'(settled ^ mask), 1'b1, 1'b1);
                check_gpio(gpio_o, model_gpio, "gpio during glitch");
            end
            for (int c = 0; c < gap; c++) begin
                step(settled, 1'b1, 1'b1);
                check_gpio(gpio_o, model_gpio, "gpio after glitch");
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
